/* hdl/cache_pkg.sv */
package cache_pkg;

    ////////////////////
    // Geometry

    localparam int data_w      = 32;
    localparam int data_bytes  = data_w / 8;
    localparam int offset_w    = 2;                        // 4 words per block
    localparam int index_w     = 3;                        // 8 lines
    localparam int tag_w       = 7;
    localparam int addr_w      = tag_w + index_w + offset_w; // Word address
    localparam int block_words = 1 << offset_w;
    localparam int num_lines   = 1 << index_w;

    typedef logic [addr_w-1:0]     addr_t;
    typedef logic [data_w-1:0]     data_t;
    typedef logic [data_bytes-1:0] byte_en_t;

    typedef enum logic [1:0] {
        st_normal,
        st_ic_fill,
        st_dc_wb,
        st_dc_fill
    } cache_state_t;

    ////////////////////
    // Line metadata
    // Valid sits in the top bit and the tag in the low bits of both layouts

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } ic_meta_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;                     // Bit just above the tag
        logic [tag_w-1:0] tag;
    } dc_meta_t;

    ////////////////////
    // Request and control bundles

    typedef struct packed {
        logic     dc_read;
        logic     dc_write;
        byte_en_t byte_en;
        addr_t    dc_addr;
        data_t    wdata;
        addr_t    ic_addr;
    } cpu_req_t;

    typedef struct packed {
        logic  en;
        logic  write;
        addr_t addr;
        data_t wdata;
    } ram_req_t;

    typedef struct packed {
        logic                word_write;             // CPU store, merge under byte_en
        byte_en_t            byte_en;
        logic                fill;                   // Refill word from memory
        logic                set_meta;               // Mark line valid and clean
        logic [offset_w-1:0] word_sel;
    } array_ctrl_t;

endpackage

/* hdl/burst_counter.sv */
module burst_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          ram_ready,
    output logic [cache_pkg::offset_w-1:0] word,
    output logic                          last
);

    // Word pointer within the block, one step per accepted memory word
    always_ff @(posedge clk) begin
        if (rst) begin
            word <= '0;
        end else if (run && ram_ready) begin
            word <= word + 1'b1;              // Wraps to zero after the fourth word
        end
    end

    assign last = (word == cache_pkg::offset_w'(cache_pkg::block_words - 1));

endmodule

/* hdl/cache_array.sv */
module cache_array #(
    parameter type meta_t = cache_pkg::ic_meta_t
) (
    input  logic                          clk,
    input  logic                          rst,
    input  cache_pkg::array_ctrl_t        ctrl,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic [cache_pkg::tag_w-1:0]   tag,
    input  cache_pkg::data_t              wdata,
    input  cache_pkg::data_t              fill_data,
    output logic                          hit,
    output meta_t                         meta,
    output cache_pkg::data_t              rdata,
    output cache_pkg::data_t              wb_data
);

    localparam int meta_w    = $bits(meta_t);
    localparam bit has_dirty = meta_w > cache_pkg::tag_w + 1;

    meta_t            meta_mem [cache_pkg::num_lines];
    cache_pkg::data_t data_mem [cache_pkg::num_lines][cache_pkg::block_words];

    logic [meta_w-1:0] cur_bits;
    logic [meta_w-1:0] fill_bits;
    logic [meta_w-1:0] dirty_bits;
    cache_pkg::data_t  sel_word;

    ////////////////////
    // Lookup

    assign cur_bits = meta_mem[index];
    assign meta     = meta_mem[index];
    assign hit      = cur_bits[meta_w-1] && (cur_bits[cache_pkg::tag_w-1:0] == tag);

    assign sel_word = data_mem[index][ctrl.word_sel];
    assign wb_data  = sel_word;                    // Victim word during writeback
    assign rdata    = hit ? sel_word : '0;         // Only a hit returns line data

    ////////////////////
    // Metadata update

    // New line after refill: valid, clean, request tag
    always_comb begin
        fill_bits = '0;
        fill_bits[meta_w-1] = 1'b1;
        fill_bits[cache_pkg::tag_w-1:0] = tag;
    end

    always_comb begin
        dirty_bits = cur_bits;
        if (has_dirty) begin
            dirty_bits[cache_pkg::tag_w] = 1'b1;   // Store hit makes the line dirty
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cache_pkg::num_lines; i++) begin
                meta_mem[i] <= '0;
            end
        end else if (ctrl.set_meta) begin
            meta_mem[index] <= meta_t'(fill_bits);
        end else if (ctrl.word_write && has_dirty) begin
            meta_mem[index] <= meta_t'(dirty_bits);
        end
    end

    ////////////////////
    // Data update

    always_ff @(posedge clk) begin
        if (ctrl.fill) begin
            data_mem[index][ctrl.word_sel] <= fill_data;
        end else if (ctrl.word_write) begin
            // Byte merge of the store data
            for (int b = 0; b < cache_pkg::data_bytes; b++) begin
                if (ctrl.byte_en[b]) begin
                    data_mem[index][ctrl.word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hdl/cache_fsm.sv */
module cache_fsm (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_pkg::cpu_req_t            cpu_req,
    input  logic                           ic_hit,
    input  logic                           dc_hit,
    input  cache_pkg::dc_meta_t            dc_meta,
    input  logic [cache_pkg::offset_w-1:0] word,
    input  logic                           last,
    input  logic                           ram_ready,
    output cache_pkg::array_ctrl_t         ic_ctrl,
    output cache_pkg::array_ctrl_t         dc_ctrl,
    output cache_pkg::ram_req_t            ram_req,
    output logic                           counter_run,
    output logic                           mem_stall,
    output logic                           dc_tag_sel
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    logic ic_miss;
    logic dc_miss;
    logic word_done;     // Last word of the burst accepted this cycle

    assign ic_miss   = !ic_hit;                    // Fetch port is always active
    assign dc_miss   = (cpu_req.dc_read || cpu_req.dc_write) && !dc_hit;
    assign word_done = ram_ready && last;

    ////////////////////
    // State register

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::st_normal;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::st_normal: begin
                // Instruction miss is served first on a double miss
                if (ic_miss) begin
                    state_next = cache_pkg::st_ic_fill;
                end else if (dc_miss) begin
                    state_next = (dc_meta.valid && dc_meta.dirty) ? cache_pkg::st_dc_wb
                                                                  : cache_pkg::st_dc_fill;
                end
            end
            cache_pkg::st_ic_fill: if (word_done) state_next = cache_pkg::st_normal;
            cache_pkg::st_dc_wb:   if (word_done) state_next = cache_pkg::st_dc_fill;
            cache_pkg::st_dc_fill: if (word_done) state_next = cache_pkg::st_normal;
            default:               state_next = cache_pkg::st_normal;
        endcase
    end

    // Miss seen in st_normal stalls in the same cycle, low while in reset
    assign mem_stall   = !rst && ((state != cache_pkg::st_normal) || ic_miss || dc_miss);
    assign counter_run = (state != cache_pkg::st_normal);
    assign dc_tag_sel  = (state == cache_pkg::st_dc_wb);   // Victim tag for writeback

    ////////////////////
    // Array controls

    always_comb begin
        ic_ctrl = '0;
        dc_ctrl = '0;

        ic_ctrl.word_sel = cpu_req.ic_addr[cache_pkg::offset_w-1:0];
        dc_ctrl.word_sel = cpu_req.dc_addr[cache_pkg::offset_w-1:0];
        dc_ctrl.byte_en  = cpu_req.byte_en;

        case (state)
            cache_pkg::st_normal: begin
                // Store completes only once both lookups hit
                dc_ctrl.word_write = cpu_req.dc_write && dc_hit && ic_hit;
            end
            cache_pkg::st_ic_fill: begin
                ic_ctrl.word_sel = word;
                ic_ctrl.fill     = ram_ready;
                ic_ctrl.set_meta = word_done;
            end
            cache_pkg::st_dc_wb: begin
                dc_ctrl.word_sel = word;           // Read-back for memory write
            end
            cache_pkg::st_dc_fill: begin
                dc_ctrl.word_sel = word;
                dc_ctrl.fill     = ram_ready;
                dc_ctrl.set_meta = word_done;
            end
            default: ;
        endcase
    end

    ////////////////////
    // Memory request

    always_comb begin
        ram_req       = '0;
        ram_req.en    = (state != cache_pkg::st_normal);  // Held for the whole burst
        ram_req.write = (state == cache_pkg::st_dc_wb);
        if (state == cache_pkg::st_ic_fill) begin
            ram_req.addr = {cpu_req.ic_addr[cache_pkg::addr_w-1:cache_pkg::offset_w], word};
        end else begin
            ram_req.addr = {cpu_req.dc_addr[cache_pkg::addr_w-1:cache_pkg::offset_w], word};
        end
    end

endmodule

/* hdl/cache_unit.sv */
module cache_unit (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                ram_ready,
    input  cache_pkg::data_t    ram_rdata,
    output logic                mem_stall,
    output cache_pkg::data_t    ic_data,
    output cache_pkg::data_t    dc_data,
    output cache_pkg::ram_req_t ram_req
);

    logic [cache_pkg::tag_w-1:0]    ic_tag;
    logic [cache_pkg::tag_w-1:0]    dc_tag;
    logic [cache_pkg::index_w-1:0]  ic_index;
    logic [cache_pkg::index_w-1:0]  dc_index;
    logic [cache_pkg::offset_w-1:0] word;

    cache_pkg::array_ctrl_t ic_ctrl;
    cache_pkg::array_ctrl_t dc_ctrl;
    cache_pkg::dc_meta_t    dc_meta;
    cache_pkg::ram_req_t    fsm_ram_req;
    cache_pkg::data_t       dc_wb_data;

    logic ic_hit;
    logic dc_hit;
    logic last;
    logic counter_run;
    logic dc_tag_sel;

    ////////////////////
    // Address fields

    assign ic_tag   = cpu_req.ic_addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
    assign ic_index = cpu_req.ic_addr[cache_pkg::offset_w +: cache_pkg::index_w];
    assign dc_tag   = cpu_req.dc_addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
    assign dc_index = cpu_req.dc_addr[cache_pkg::offset_w +: cache_pkg::index_w];

    // Writeback goes to the victim's tag, same index and word
    always_comb begin
        ram_req = fsm_ram_req;
        if (dc_tag_sel) begin
            ram_req.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w] = dc_meta.tag;
        end
        ram_req.wdata = dc_wb_data;
    end

    cache_fsm cache_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .ic_hit      (ic_hit),
        .dc_hit      (dc_hit),
        .dc_meta     (dc_meta),
        .word        (word),
        .last        (last),
        .ram_ready   (ram_ready),
        .ic_ctrl     (ic_ctrl),
        .dc_ctrl     (dc_ctrl),
        .ram_req     (fsm_ram_req),
        .counter_run (counter_run),
        .mem_stall   (mem_stall),
        .dc_tag_sel  (dc_tag_sel)
    );

    burst_counter burst_counter_inst (
        .clk       (clk),
        .rst       (rst),
        .run       (counter_run),
        .ram_ready (ram_ready),
        .word      (word),
        .last      (last)
    );

    cache_array #(.meta_t(cache_pkg::ic_meta_t)) ic_array (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ic_ctrl),
        .index     (ic_index),
        .tag       (ic_tag),
        .wdata     ('0),                          // Read-only from the CPU side
        .fill_data (ram_rdata),
        .hit       (ic_hit),
        .meta      (),
        .rdata     (ic_data),
        .wb_data   ()
    );

    cache_array #(.meta_t(cache_pkg::dc_meta_t)) dc_array (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (dc_ctrl),
        .index     (dc_index),
        .tag       (dc_tag),
        .wdata     (cpu_req.wdata),
        .fill_data (ram_rdata),
        .hit       (dc_hit),
        .meta      (dc_meta),
        .rdata     (dc_data),
        .wb_data   (dc_wb_data)
    );

endmodule

/* test/cache_tb_asserts.sv */
module cache_tb_asserts (
    input logic                    clk,
    input logic                    rst,
    input cache_pkg::cache_state_t state,
    input cache_pkg::cpu_req_t     cpu_req,
    input logic                    last,
    input logic                    ram_ready,
    input cache_pkg::ram_req_t     ram_req,
    input logic                    mem_stall
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;        // Watched by the testbench monitor
    logic dc_active;

    assign dc_active = cpu_req.dc_read || cpu_req.dc_write;

    // A burst only starts after a stalled miss
    burst_start: assert property (@(posedge clk) disable iff (rst)
        $rose(ram_req.en) |-> $past(mem_stall))
    else begin
        $error("memory request started without a pending miss");
        fail_count++;
    end

    // Address and direction hold until memory takes the word
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        ram_req.en && !ram_ready |=> $stable(ram_req.addr) && $stable(ram_req.write))
    else begin
        $error("memory address changed without a ram_ready strobe");
        fail_count++;
    end

    // Held request hits right after its last fill word
    fill_then_hit: assert property (@(posedge clk) disable iff (rst)
        ram_ready && last && ((state == cache_pkg::st_dc_fill) ||
                              ((state == cache_pkg::st_ic_fill) && !dc_active))
        |=> (state == cache_pkg::st_normal) && !mem_stall)
    else begin
        $error("stall held in the normal state after the line was filled");
        fail_count++;
    end

endmodule

bind cache_fsm cache_tb_asserts cache_tb_asserts_inst (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .cpu_req   (cpu_req),
    .last      (last),
    .ram_ready (ram_ready),
    .ram_req   (ram_req),
    .mem_stall (mem_stall)
);

/* test/cache_tb.sv */
module cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_rows    = 16;
    localparam int mem_words   = 1 << cache_pkg::addr_w;
    localparam int cycle_limit = num_rows * 64 + 200;
    localparam cache_pkg::data_t fill_pattern = 32'hc0de_0000;

    typedef enum logic [1:0] {
        op_fetch,
        op_load,
        op_store,
        op_both                                // Fetch and load in the same cycle
    } op_t;

    typedef struct packed {
        op_t                 op;
        cache_pkg::addr_t    ic_addr;
        cache_pkg::addr_t    dc_addr;
        cache_pkg::data_t    wdata;
        cache_pkg::byte_en_t byte_en;
        cache_pkg::data_t    exp_ic;
        cache_pkg::data_t    exp_dc;
        int                  exp_wr;           // Memory write words until completion
        logic                no_mem;           // Pure hit, no request at all
        cache_pkg::addr_t    wb_base;          // First writeback address
    } row_t;

    logic                clk = 1'b0;
    logic                rst;
    cache_pkg::cpu_req_t cpu_req;
    logic                ram_ready;
    cache_pkg::data_t    ram_rdata;
    logic                mem_stall;
    cache_pkg::data_t    ic_data;
    cache_pkg::data_t    dc_data;
    cache_pkg::ram_req_t ram_req;

    cache_pkg::data_t mem [mem_words];
    cache_pkg::addr_t wr_addrs [$];
    row_t             rows [num_rows];
    logic [31:0]      rng_state;
    int               wr_words;
    int               en_cycles;
    int               cycles = 0;

    always #2 clk = ~clk;

    cache_unit cache_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .ram_ready (ram_ready),
        .ram_rdata (ram_rdata),
        .mem_stall (mem_stall),
        .ic_data   (ic_data),
        .dc_data   (dc_data),
        .ram_req   (ram_req)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    ////////////////////
    // Compare tasks

    task automatic check_data(input string name, input cache_pkg::data_t got,
                              input cache_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    ////////////////////
    // Memory model

    // Content is address XOR pattern, one random ready decision per cycle
    initial begin
        ram_ready = 1'b0;
        ram_rdata = '0;
        rng_state = 32'd99;
        wr_words  = 0;
        en_cycles = 0;
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = fill_pattern ^ cache_pkg::data_t'(a);
        end
        forever begin
            @(negedge clk);
            rng_state = xorshift(rng_state);
            if (ram_req.en === 1'b1) begin
                en_cycles++;
                ram_ready = rng_state[0];
                ram_rdata = mem[ram_req.addr];
                if (ram_ready && ram_req.write) begin
                    mem[ram_req.addr] = ram_req.wdata;
                    wr_addrs.push_back(ram_req.addr);
                    wr_words++;
                end
            end else begin
                ram_ready = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the accesses did not finish within %0d cycles", cycle_limit);
            stop_run();
        end else if (cache_unit_inst.cache_fsm_inst.cache_tb_asserts_inst.fail_count != 0) begin
            $display("A protocol assertion failed");
            stop_run();
        end
    end

    ////////////////////
    // Stimulus

    // Expected words follow from the memory content and earlier stores
    task automatic load_rows();
        //            op        ic       dc       wdata         byte_en
        //            exp_ic        exp_dc        wr no_mem wb_base
        rows[0]  = '{op_fetch, 12'h010, 12'h000, 32'h00000000, 4'b0000,
                     32'hc0de0010, 32'h00000000, 0, 1'b0, 12'h000};
        rows[1]  = '{op_fetch, 12'h013, 12'h000, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'h00000000, 0, 1'b1, 12'h000};
        rows[2]  = '{op_load,  12'h013, 12'h104, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'hc0de0104, 0, 1'b0, 12'h000};
        rows[3]  = '{op_load,  12'h013, 12'h106, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'hc0de0106, 0, 1'b1, 12'h000};
        rows[4]  = '{op_store, 12'h013, 12'h105, 32'h11223344, 4'b0101,
                     32'hc0de0013, 32'h00000000, 0, 1'b1, 12'h000};
        rows[5]  = '{op_load,  12'h013, 12'h105, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'hc0220144, 0, 1'b1, 12'h000};
        rows[6]  = '{op_store, 12'h013, 12'h107, 32'hdeadbeef, 4'b1100,
                     32'hc0de0013, 32'h00000000, 0, 1'b1, 12'h000};
        rows[7]  = '{op_load,  12'h013, 12'h124, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'hc0de0124, 4, 1'b0, 12'h104};
        rows[8]  = '{op_load,  12'h013, 12'h105, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'hc0220144, 0, 1'b0, 12'h000};
        rows[9]  = '{op_load,  12'h013, 12'h107, 32'h00000000, 4'b0000,
                     32'hc0de0013, 32'hdead0107, 0, 1'b1, 12'h000};
        rows[10] = '{op_both,  12'h2a0, 12'h3c9, 32'h00000000, 4'b0000,
                     32'hc0de02a0, 32'hc0de03c9, 0, 1'b0, 12'h000};
        rows[11] = '{op_store, 12'h2a0, 12'h3ca, 32'h000000ff, 4'b0001,
                     32'hc0de02a0, 32'h00000000, 0, 1'b1, 12'h000};
        rows[12] = '{op_both,  12'h0b2, 12'h0ca, 32'h00000000, 4'b0000,
                     32'hc0de00b2, 32'hc0de00ca, 4, 1'b0, 12'h3c8};
        rows[13] = '{op_load,  12'h0b2, 12'h3ca, 32'h00000000, 4'b0000,
                     32'hc0de00b2, 32'hc0de03ff, 0, 1'b0, 12'h000};
        rows[14] = '{op_fetch, 12'h010, 12'h000, 32'h00000000, 4'b0000,
                     32'hc0de0010, 32'h00000000, 0, 1'b0, 12'h000};
        rows[15] = '{op_fetch, 12'h011, 12'h000, 32'h00000000, 4'b0000,
                     32'hc0de0011, 32'h00000000, 0, 1'b1, 12'h000};
    endtask

    // Called on a falling edge, returns on the falling edge after completion
    task automatic apply_row(input row_t r, input int n);
        int   wr_start;
        int   en_start;
        int   q_start;
        logic dc_used;
        dc_used          = (r.op == op_load) || (r.op == op_both);
        cpu_req          = '0;
        cpu_req.ic_addr  = r.ic_addr;
        cpu_req.dc_addr  = r.dc_addr;
        cpu_req.dc_read  = dc_used;
        cpu_req.dc_write = (r.op == op_store);
        cpu_req.wdata    = r.wdata;
        cpu_req.byte_en  = r.byte_en;
        #1;
        wr_start = wr_words;
        en_start = en_cycles;
        q_start  = wr_addrs.size();
        while (mem_stall !== 1'b0) begin
            @(negedge clk);
            #1;
        end
        // Request completes at the coming rising edge
        check_data($sformatf("row %0d ic_data", n), ic_data, r.exp_ic);
        if (dc_used) begin
            check_data($sformatf("row %0d dc_data", n), dc_data, r.exp_dc);
        end
        check_count($sformatf("row %0d memory write words", n), wr_words - wr_start, r.exp_wr);
        if (r.no_mem) begin
            check_count($sformatf("row %0d ram_req.en cycles", n), en_cycles - en_start, 0);
        end
        for (int k = 0; k < wr_words - wr_start; k++) begin
            check_addr($sformatf("row %0d ram_req.addr", n), wr_addrs[q_start + k],
                       r.wb_base + cache_pkg::addr_t'(k));
        end
        @(negedge clk);
    endtask

    initial begin
        rst     = 1'b1;
        cpu_req = '0;
        load_rows();
        repeat (8) @(negedge clk);
        check_count("mem_stall", int'(mem_stall), 0);
        check_count("ram_req.en", int'(ram_req.en), 0);
        check_count("ram_req.write", int'(ram_req.write), 0);
        rst = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i], i);
        end
        if (cache_unit_inst.cache_fsm_inst.cache_tb_asserts_inst.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Protocol assertions failed during the run");
            stop_run();
        end
    end

endmodule

/* all.f */
hdl/cache_pkg.sv
hdl/burst_counter.sv
hdl/cache_array.sv
hdl/cache_fsm.sv
hdl/cache_unit.sv
test/cache_tb_asserts.sv
test/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
